// ==== sim/ecc_86_tests.txt ====
# name data_in parity_in bypass stall exp_data_out exp_parity_out exp_sbit exp_dbit
# all fields hex except stall (decimal cycles of out_ready low), data as 22 hex digits
clean_zero 0000000000000000000000 00 0 0 0000000000000000000000 00 0 0
clean_a 1000000300000002000814 23 0 0 1000000300000002000814 23 0 0
clean_b 000000000000000000000f 87 0 3 000000000000000000000f 87 0 0
clean_top 2000000000000000000000 5d 0 0 2000000000000000000000 5d 0 0
flip_d0 1000000300000002000815 23 0 0 1000000300000002000814 a0 1 0
flip_d42 1000000300040002000814 23 0 5 1000000300000002000814 12 1 0
flip_d85 3000000300000002000814 23 0 3 1000000300000002000814 7e 1 0
flip_d57 1000000100000002000814 23 0 0 1000000300000002000814 e2 1 0
flip_p0 1000000300000002000814 22 0 0 1000000300000002000814 23 1 0
flip_p1 1000000300000002000814 21 0 0 1000000300000002000814 23 1 0
flip_p2 1000000300000002000814 27 0 0 1000000300000002000814 23 1 0
flip_p3 1000000300000002000814 2b 0 0 1000000300000002000814 23 1 0
flip_p4 1000000300000002000814 33 0 2 1000000300000002000814 23 1 0
flip_p5 1000000300000002000814 03 0 0 1000000300000002000814 23 1 0
flip_p6 1000000300000002000814 63 0 0 1000000300000002000814 23 1 0
flip_p7 1000000300000002000814 a3 0 0 1000000300000002000814 23 1 0
dbl_d0_d1 1000000300000002000817 23 0 4 1000000300000002000817 25 0 1
dbl_d85_p3 3000000300000002000814 2b 0 0 3000000300000002000814 7e 0 1
dbl_p0_p7 1000000300000002000814 a2 0 0 1000000300000002000814 23 0 1
byp_bad_par 000000000000000000000f 5a 1 1 000000000000000000000f 87 0 0
byp_flip_d0 1000000300000002000815 23 1 0 1000000300000002000815 a0 0 0

// ==== project.f ====
+incdir+hw
hw/ecc_pkg.sv
hw/ecc_stage_if.sv
hw/ecc_parity_gen.sv
hw/ecc_syndrome_stage.sv
hw/ecc_syndrome_decode.sv
hw/ecc_correct_stage.sv
hw/ecc_86_top.sv
sim/ecc_86_checker.sv
sim/ecc_86_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f project.f \
    --top-module ecc_86_tb -o ecc_86_sim

sim_out=$(./obj_dir/ecc_86_sim)
echo "$sim_out"
grep -q "Regression passed" <<< "$sim_out"

// ==== sim/ecc_86_tb.sv ====
`include "ecc_macros.svh"

module ecc_86_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS = 64;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     in_valid;
    logic                     in_ready;
    logic [`ECC_DATA_W-1:0]   data_in;
    logic [`ECC_PARITY_W-1:0] parity_in;
    logic                     bypass;
    logic                     out_valid;
    logic                     out_ready;
    logic [`ECC_DATA_W-1:0]   data_out;
    logic [`ECC_PARITY_W-1:0] parity_out;
    logic [`ECC_DATA_W-1:0]   mask;
    logic                     sbit_err;
    logic                     dbit_err;
    int                       checked;
    int                       errors;
    int                       pending;

    // ~~~~~~~~~~~~~~~~~~~~
    // test table
    // ~~~~~~~~~~~~~~~~~~~~
    string                    t_name     [MAX_TESTS];
    logic [`ECC_DATA_W-1:0]   t_data     [MAX_TESTS];
    logic [`ECC_PARITY_W-1:0] t_parity   [MAX_TESTS];
    logic                     t_bypass   [MAX_TESTS];
    int                       t_stall    [MAX_TESTS];  // out_ready low cycles
    logic [`ECC_DATA_W-1:0]   t_exp_data [MAX_TESTS];
    logic [`ECC_PARITY_W-1:0] t_exp_par  [MAX_TESTS];
    logic                     t_exp_sbit [MAX_TESTS];
    logic                     t_exp_dbit [MAX_TESTS];

    int   num_tests   = 0;
    int   load_errors = 0;
    int   timeout_ns  = 0;
    int   stall_left  = 0;  // runs on while later words are offered
    logic loaded      = 1'b0;

    always #2 clk = ~clk;

    ecc_86_top ecc_86_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    ecc_86_checker check_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .checked    (checked),
        .errors     (errors),
        .pending    (pending)
    );

    task automatic load_tests();
        int                       fd;
        int                       n;
        string                    line;
        string                    name;
        logic [`ECC_DATA_W-1:0]   d;
        logic [`ECC_PARITY_W-1:0] p;
        logic                     b;
        int                       stall;
        logic [`ECC_DATA_W-1:0]   ed;
        logic [`ECC_PARITY_W-1:0] ep;
        logic                     es;
        logic                     edb;
        fd = $fopen("sim/ecc_86_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file sim/ecc_86_tests.txt");
            load_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %d %h %h %h %h",
                                name, d, p, b, stall, ed, ep, es, edb);
                    if (n != 9 || num_tests == MAX_TESTS) begin
                        $display("a line of the test file was malformed or beyond the table");
                        load_errors++;
                    end else begin
                        t_name[num_tests]     = name;
                        t_data[num_tests]     = d;
                        t_parity[num_tests]   = p;
                        t_bypass[num_tests]   = b;
                        t_stall[num_tests]    = stall;
                        t_exp_data[num_tests] = ed;
                        t_exp_par[num_tests]  = ep;
                        t_exp_sbit[num_tests] = es;
                        t_exp_dbit[num_tests] = edb;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // entered 1 ns after a rising edge, leaves the same way
    task automatic send_word(input int t);
        logic accepted;
        logic take;
        accepted   = 1'b0;
        stall_left += t_stall[t];
        in_valid   = 1'b1;
        data_in    = t_data[t];
        parity_in  = t_parity[t];
        bypass     = t_bypass[t];
        out_ready  = (stall_left == 0);
        while (!accepted) begin
            @(negedge clk);
            take = in_valid & in_ready;
            @(posedge clk);
            if (take) begin
                accepted = 1'b1;
                // a corrected word differs from its input only in the flipped bit
                check_i.push_expected(t_name[t], t_exp_data[t], t_exp_par[t],
                                      t_data[t] ^ t_exp_data[t], t_exp_sbit[t], t_exp_dbit[t]);
            end
            #1;
            if (accepted) begin
                in_valid = 1'b0;
            end
            if (stall_left > 0) begin
                stall_left--;
            end
            out_ready = (stall_left == 0);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        out_ready = 1'b1;
        load_tests();
        timeout_ns = 8;  // reset
        for (int t = 0; t < num_tests; t++) begin
            timeout_ns += (t_stall[t] + 10) * 4;
        end
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            send_word(t);
        end
        while (stall_left > 0) begin
            @(posedge clk);
            #1;
            stall_left--;
            out_ready = (stall_left == 0);
        end
        wait (pending == 0);
        @(negedge clk);
        $display("%0d of %0d words checked, %0d errors, %0d test file errors",
                 checked, num_tests, errors, load_errors);
        if (errors == 0 && load_errors == 0 && num_tests > 0 && checked == num_tests) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // watchdog
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        wait (loaded);
        #(timeout_ns);
        $display("the run timed out after %0d ns", timeout_ns);
        $display("%0d words went into the DUT and never came out", pending);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== sim/ecc_86_checker.sv ====
`include "ecc_macros.svh"

module ecc_86_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     out_valid,
    input  logic                     out_ready,
    input  logic [`ECC_DATA_W-1:0]   data_out,
    input  logic [`ECC_PARITY_W-1:0] parity_out,
    input  logic [`ECC_DATA_W-1:0]   mask,
    input  logic                     sbit_err,
    input  logic                     dbit_err,
    output int                       checked,
    output int                       errors,
    output int                       pending
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [`ECC_DATA_W-1:0] word_t;

    // expected words, oldest first
    string                    name_q   [$];
    word_t                    data_q   [$];
    logic [`ECC_PARITY_W-1:0] parity_q [$];
    word_t                    mask_q   [$];
    logic                     sbit_q   [$];
    logic                     dbit_q   [$];

    int n_checked = 0;
    int n_errors  = 0;
    int n_pushed  = 0;
    int n_popped  = 0;

    assign checked = n_checked;
    assign errors  = n_errors;
    assign pending = n_pushed - n_popped;

    function automatic void push_expected(input string test, input word_t data,
                                          input logic [`ECC_PARITY_W-1:0] parity,
                                          input word_t m, input logic sbit, input logic dbit);
        name_q.push_back(test);
        data_q.push_back(data);
        parity_q.push_back(parity);
        mask_q.push_back(m);
        sbit_q.push_back(sbit);
        dbit_q.push_back(dbit);
        n_pushed++;
    endfunction

    task automatic check_field(input string test, input string field,
                               input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("error %s %s expected %0h actual %0h", test, field, exp, act);
            n_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // output handshake
    // ~~~~~~~~~~~~~~~~~~~~
    // outputs hold still from the drive point to the edge, so look at negedge
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (name_q.size() == 0) begin
                $display("an output word came out with no input word left to match it");
                n_errors++;
            end else begin
                check_field(name_q[0], "data_out", data_q[0], data_out);
                check_field(name_q[0], "parity_out", word_t'(parity_q[0]), word_t'(parity_out));
                check_field(name_q[0], "mask", mask_q[0], mask);
                check_field(name_q[0], "sbit_err", word_t'(sbit_q[0]), word_t'(sbit_err));
                check_field(name_q[0], "dbit_err", word_t'(dbit_q[0]), word_t'(dbit_err));
                void'(name_q.pop_front());
                void'(data_q.pop_front());
                void'(parity_q.pop_front());
                void'(mask_q.pop_front());
                void'(sbit_q.pop_front());
                void'(dbit_q.pop_front());
                n_popped++;
                n_checked++;
            end
        end
    end

endmodule

// ==== hw/ecc_86_top.sv ====
`include "ecc_macros.svh"

module ecc_86_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`ECC_DATA_W-1:0]   data_in,
    input  logic [`ECC_PARITY_W-1:0] parity_in,
    input  logic                     bypass,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`ECC_DATA_W-1:0]   data_out,
    output logic [`ECC_PARITY_W-1:0] parity_out,
    output logic [`ECC_DATA_W-1:0]   mask,
    output logic                     sbit_err,
    output logic                     dbit_err
);

    ecc_stage_if stage_if ();

    // encode and syndrome
    ecc_syndrome_stage u_syndrome_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .data_in   (data_in),
        .parity_in (parity_in),
        .bypass    (bypass),
        .out       (stage_if.src)
    );

    // decode and correct
    ecc_correct_stage u_correct_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (stage_if.dst),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

// ==== hw/ecc_correct_stage.sv ====
`include "ecc_macros.svh"

module ecc_correct_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    ecc_stage_if.dst                 in,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`ECC_DATA_W-1:0]   data_out,
    output logic [`ECC_PARITY_W-1:0] parity_out,
    output logic [`ECC_DATA_W-1:0]   mask,
    output logic                     sbit_err,
    output logic                     dbit_err
);

    logic [`ECC_DATA_W-1:0] dec_mask;
    logic                   dec_sbit;
    logic                   dec_dbit;
    logic [`ECC_DATA_W-1:0] use_mask;

    ecc_syndrome_decode u_decode (
        .syndrome (in.syndrome),
        .mask     (dec_mask),
        .sbit_err (dec_sbit),
        .dbit_err (dec_dbit)
    );

    assign use_mask = in.bypass ? '0 : dec_mask;  // bypass hides all errors
    assign in.ready = ~out_valid | out_ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in.ready) begin
            out_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            data_out   <= in.data ^ use_mask;
            parity_out <= in.parity;
            mask       <= use_mask;
            sbit_err   <= dec_sbit & ~in.bypass;
            dbit_err   <= dec_dbit & ~in.bypass;
        end
    end

    // never more than one bit corrected per word
    a_mask_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $onehot0(mask));

endmodule

// ==== hw/ecc_syndrome_decode.sv ====
`include "ecc_macros.svh"

module ecc_syndrome_decode (
    input  ecc_pkg::syndrome_t     syndrome,
    output logic [`ECC_DATA_W-1:0] mask,
    output logic                   sbit_err,
    output logic                   dbit_err
);
    import ecc_pkg::*;

    logic no_err;
    logic data_hit;
    logic check_hit;

    // a match on both fields points at exactly one data bit
    for (genvar i = 0; i < `ECC_DATA_W; i++) begin : g_col
        localparam logic [`ECC_PARITY_W-1:0] COL = data_column(i);
        assign mask[i] = (syndrome.split.pos == COL[`ECC_POS_W-1:0]) &&
                         (syndrome.split.overall == COL[`ECC_PARITY_W-1]);
    end

    assign no_err    = (syndrome.raw == '0);
    assign data_hit  = |mask;
    assign check_hit = $onehot(syndrome.raw);  // flipped check bit, data is fine

    assign sbit_err = data_hit | check_hit;
    assign dbit_err = ~no_err & ~data_hit & ~check_hit;

    // a flipped check bit never looks like a data column
    always_comb begin
        a_check_not_data: assert (!(data_hit && check_hit));
    end

endmodule

// ==== hw/ecc_syndrome_stage.sv ====
`include "ecc_macros.svh"

module ecc_syndrome_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`ECC_DATA_W-1:0]   data_in,
    input  logic [`ECC_PARITY_W-1:0] parity_in,
    input  logic                     bypass,
    ecc_stage_if.src                 out
);
    import ecc_pkg::*;

    logic [`ECC_PARITY_W-1:0] fresh_parity;
    syndrome_t                syndrome;

    ecc_parity_gen u_parity_gen (
        .data   (data_in),
        .parity (fresh_parity)
    );

    assign syndrome = syndrome_t'(parity_in ^ fresh_parity);

    // free slot, or the word leaves this cycle
    assign in_ready = ~out.valid | out.ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // stage register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else if (in_ready) begin
            out.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out.data     <= data_in;
            out.parity   <= fresh_parity;
            out.syndrome <= syndrome;
            out.bypass   <= bypass;
        end
    end

    // stalled word must not change until taken
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out.valid && !out.ready |=>
            out.valid && $stable({out.data, out.parity, out.syndrome, out.bypass}));

endmodule

// ==== hw/ecc_parity_gen.sv ====
`include "ecc_macros.svh"

module ecc_parity_gen (
    input  logic [`ECC_DATA_W-1:0]   data,
    output logic [`ECC_PARITY_W-1:0] parity
);
    import ecc_pkg::*;

    // one xor tree per check bit
    for (genvar j = 0; j < `ECC_PARITY_W; j++) begin : g_check
        logic [`ECC_DATA_W-1:0] sel_bits;

        for (genvar i = 0; i < `ECC_DATA_W; i++) begin : g_term
            localparam logic [`ECC_PARITY_W-1:0] COL = data_column(i);
            assign sel_bits[i] = data[i] & COL[j];  // const, folds away
        end

        assign parity[j] = ^sel_bits;
    end

endmodule

// ==== hw/ecc_stage_if.sv ====
`include "ecc_macros.svh"

interface ecc_stage_if;
    import ecc_pkg::*;

    logic                     valid;
    logic                     ready;
    logic [`ECC_DATA_W-1:0]   data;
    logic [`ECC_PARITY_W-1:0] parity;    // freshly encoded check bits
    syndrome_t                syndrome;
    logic                     bypass;

    modport src (
        output valid, data, parity, syndrome, bypass,
        input  ready
    );

    modport dst (
        input  valid, data, parity, syndrome, bypass,
        output ready
    );

endinterface

// ==== hw/ecc_pkg.sv ====
`include "ecc_macros.svh"

package ecc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // syndrome word
    // ~~~~~~~~~~~~~~~~~~~~
    typedef union packed {
        logic [`ECC_PARITY_W-1:0] raw;
        struct packed {
            logic                  overall;
            logic [`ECC_POS_W-1:0] pos;
        } split;
    } syndrome_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // column table
    // ~~~~~~~~~~~~~~~~~~~~
    // data bit idx sits at the idx-th non power of two position from 3 up;
    // the top bit marks a position with an even count of ones
    function automatic logic [`ECC_PARITY_W-1:0] data_column(input int unsigned idx);
        int unsigned              cnt;
        logic [`ECC_POS_W-1:0]    p;
        logic [`ECC_PARITY_W-1:0] col;
        cnt = 0;
        p   = '0;
        col = '0;
        for (int unsigned pos = 3; pos < 2**`ECC_POS_W; pos++) begin
            if ((pos & (pos - 1)) != 0) begin  // skip check bit slots
                if (cnt == idx) begin
                    p   = pos[`ECC_POS_W-1:0];
                    col = {~(^p), p};
                end
                cnt++;
            end
        end
        return col;
    endfunction

endpackage

// ==== hw/ecc_macros.svh ====
`ifndef ECC_MACROS_SVH
`define ECC_MACROS_SVH

// data word width
`define ECC_DATA_W   86

// check bits, 7 hamming plus one overall
`define ECC_PARITY_W 8

// hamming position field
`define ECC_POS_W    7

`endif
